/* hw/ula_pkg.sv */
`default_nettype none

package ula_pkg;

	////////////////////////////////////////////////////////////
	// Plain vector types
	////////////////////////////////////////////////////////////

	typedef logic [8:0]  hcount_t;   // Horizontal beam position, pixel clocks
	typedef logic [8:0]  vcount_t;   // Scan line number
	typedef logic [13:0] vaddr_t;    // 16 KB video RAM
	typedef logic [3:0]  irgb_t;     // Bright, G, R, B
	typedef logic [5:0]  pal_addr_t; // ULAplus palette index
	typedef logic [7:0]  gggrrrbb_t; // ULAplus colour byte

	// Four clk28 ticks per pixel
	typedef enum logic [1:0] {
		SEQ0,
		SEQ1,
		SEQ2,
		SEQ3   // Last tick, pixel enable
	} seq_phase_t;

	////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////

	typedef struct packed {
		hcount_t hc;
		vcount_t vc;
	} beam_t;

	// Z80 side, all strobes active low
	typedef struct packed {
		logic [15:0] a;
		logic        iorq_n;
		logic        rd_n;
		logic        wr_n;
		logic [7:0]  din;
	} cpu_bus_t;

	// 9-bit colour towards the DAC
	typedef struct packed {
		logic [2:0] r;
		logic [2:0] g;
		logic [2:0] b;
	} rgb_t;

	typedef struct packed {
		logic      we;
		pal_addr_t addr;
		gggrrrbb_t data;
	} pal_wr_t;

	////////////////////////////////////////////////////////////
	// Screen geometry, all ends inclusive
	////////////////////////////////////////////////////////////

	localparam hcount_t H_PIX_END     = 9'd255;           // 256 bitmap pixels
	localparam hcount_t H_BORDER_END  = 9'd319;           // Right border
	localparam hcount_t H_BLANK_START = H_BORDER_END + 9'd1;
	localparam hcount_t H_BLANK_END   = 9'd415;           // Left border follows up to wrap
	localparam hcount_t H_SYNC_START  = 9'd344;
	localparam hcount_t H_SYNC_END    = 9'd375;

	localparam vcount_t V_PIX_END     = 9'd191;           // 192 bitmap lines
	localparam vcount_t V_BORDER_END  = 9'd247;           // Bottom border
	localparam vcount_t V_BLANK_START = V_BORDER_END + 9'd1;
	localparam vcount_t V_BLANK_END   = 9'd255;
	localparam vcount_t V_SYNC_START  = 9'd248;
	localparam vcount_t V_SYNC_END    = 9'd251;

	localparam vcount_t INT_LINE = 9'd248;  // First blanked line
	localparam hcount_t INT_LEN  = 9'd64;   // Pixel clocks, 256 clk28

endpackage

`default_nettype wire

/* hw/pal_sync_generator.sv */
`timescale 1ns/1ps
`default_nettype none

module pal_sync_generator import ula_pkg::*; #(
	parameter int H_TOTAL = 448,
	parameter int V_TOTAL = 312
) (
	input  wire        clk28,
	input  wire        rst_n,
	input  wire        pix_en,   // One clk28 in four
	input  wire  rgb_t rgb_in,   // Colour of the current beam position
	output beam_t      beam,
	output rgb_t       rgb_out,
	output logic       csync
);

	hcount_t hc;
	vcount_t vc;
	logic    line_end;
	logic    frame_end;
	logic    h_sync;
	logic    v_sync;
	logic    blanking;

	assign line_end  = (hc == hcount_t'(H_TOTAL - 1));
	assign frame_end = (vc == vcount_t'(V_TOTAL - 1));

	////////////////////////////////////////////////////////////
	// Beam counters
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk28) begin
		if (!rst_n) begin
			hc <= '0;
			vc <= '0;
		end else if (pix_en) begin
			if (line_end) begin
				hc <= '0;
				vc <= frame_end ? '0 : vc + 9'd1;  // Wrap at V_TOTAL
			end else begin
				hc <= hc + 9'd1;
			end
		end
	end

	assign beam = '{hc: hc, vc: vc};

	////////////////////////////////////////////////////////////
	// Sync and blanking windows
	////////////////////////////////////////////////////////////

	assign h_sync = (hc >= H_SYNC_START) && (hc <= H_SYNC_END);
	assign v_sync = (vc >= V_SYNC_START) && (vc <= V_SYNC_END);

	// Either axis blanked kills the colour
	assign blanking = ((hc >= H_BLANK_START) && (hc <= H_BLANK_END)) ||
		((vc >= V_BLANK_START) && (vc <= V_BLANK_END));

	// Output stage, changes only on the pixel enable
	always_ff @(posedge clk28) begin
		if (!rst_n) begin
			rgb_out <= '0;
			csync   <= 1'b1;
		end else if (pix_en) begin
			rgb_out <= blanking ? '0 : rgb_in;
			// Line pulses invert inside vsync, serrated field pulse
			csync   <= ~(h_sync ^ v_sync);
		end
	end

endmodule

`default_nettype wire

/* hw/ulaplus_palette_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module ulaplus_palette_ram import ula_pkg::*; (
	input  wire            clk28,
	input  wire pal_wr_t   wr,        // From the I/O block
	input  wire pal_addr_t cpu_addr,
	output gggrrrbb_t      cpu_data,
	input  wire pal_addr_t vid_addr,  // From the video fetch
	output gggrrrbb_t      vid_data
);

	// 64 colour entries, four groups of 16
	gggrrrbb_t mem [64];

	always_ff @(posedge clk28) begin
		if (wr.we)
			mem[wr.addr] <= wr.data;

		// CPU port sees its own write straight away
		if (wr.we && (wr.addr == cpu_addr))
			cpu_data <= wr.data;
		else
			cpu_data <= mem[cpu_addr];

		vid_data <= mem[vid_addr];  // One cycle behind vid_addr
	end

endmodule

`default_nettype wire

/* hw/ula_io_ports.sv */
`timescale 1ns/1ps
`default_nettype none

module ula_io_ports import ula_pkg::*; (
	input  wire            clk28,
	input  wire            rst_n,
	input  wire cpu_bus_t  bus,
	output logic [7:0]     dout,
	input  wire            ear,
	input  wire [4:0]      kbd,           // Half-row, active low
	output pal_wr_t        pal_wr,
	output pal_addr_t      pal_cpu_addr,
	input  wire gggrrrbb_t pal_cpu_data,
	output logic [2:0]     border,
	output logic           ulaplus_en,
	output logic           mic,
	output logic           spk
);

	logic       port_fe;
	logic       port_bf3b;
	logic       port_ff3b;
	logic       wr_act;
	logic       rd_act;
	logic [7:0] ulaplus_sel;   // Written through BF3B
	logic       sel_pal;
	logic       sel_mode;
	logic       mode256x256;   // Mode bit 1, stored only

	////////////////////////////////////////////////////////////
	// Address decode
	////////////////////////////////////////////////////////////

	assign port_fe   = ~bus.a[0];               // Any even port
	assign port_bf3b = (bus.a == 16'hBF3B);
	assign port_ff3b = (bus.a == 16'hFF3B);

	assign wr_act = ~bus.iorq_n & ~bus.wr_n;
	assign rd_act = ~bus.iorq_n & ~bus.rd_n;

	// Select group 00 is the palette, 40 the mode register
	assign sel_pal  = (ulaplus_sel[7:6] == 2'b00);
	assign sel_mode = (ulaplus_sel == 8'h40);

	// Registers load every edge while the write level holds
	always_ff @(posedge clk28) begin
		if (!rst_n) begin
			border      <= '0;
			mic         <= 1'b0;
			spk         <= 1'b0;
			ulaplus_sel <= '0;
			mode256x256 <= 1'b0;
			ulaplus_en  <= 1'b0;
		end else if (wr_act) begin
			if (port_fe)
				{spk, mic, border} <= bus.din[4:0];  // Bits 7..5 ignored
			if (port_bf3b)
				ulaplus_sel <= bus.din;
			if (port_ff3b && sel_mode)
				{mode256x256, ulaplus_en} <= bus.din[1:0];
		end
	end

	////////////////////////////////////////////////////////////
	// Palette side
	////////////////////////////////////////////////////////////

	assign pal_wr = '{
		we:   wr_act & port_ff3b & sel_pal,
		addr: ulaplus_sel[5:0],
		data: bus.din
	};

	// Select holds still during the read, so the entry is ready
	assign pal_cpu_addr = ulaplus_sel[5:0];

	// Read mux, combinational off the address
	always_comb begin
		dout = 8'hFF;  // Idle bus
		if (rd_act) begin
			if (port_fe) begin
				dout = {1'b1, ear, 1'b1, kbd};
			end else if (port_ff3b) begin
				if (sel_pal)
					dout = pal_cpu_data;
				else if (sel_mode)
					dout = {6'b000000, mode256x256, ulaplus_en};
			end
		end
	end

endmodule

`default_nettype wire

/* hw/ula_video_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module ula_video_fetch import ula_pkg::*; (
	input  wire             clk28,
	input  wire             rst_n,
	input  wire seq_phase_t phase,
	input  wire beam_t      beam,
	input  wire [2:0]       border,
	input  wire             ulaplus_en,
	output vaddr_t          va,
	input  wire [7:0]       vramdata,   // Answers va in the same cycle
	output pal_addr_t       pal_addr,
	input  wire gggrrrbb_t  pal_data,
	output rgb_t            rgb
);

	logic [2:0] cell_pix;     // Pixel inside the 8-pixel cell
	logic [4:0] col;          // Character column
	logic       fetch_area;
	logic       data_latch, attr_latch, paper_latch, ink_latch;
	logic       border_latch, out_latch, sload;
	logic [7:0] bitmap;       // Next cell, fetched one cell ahead
	logic [7:0] attr;
	gggrrrbb_t  paper_plus, ink_plus, border_plus;
	logic [7:0] shifter;
	irgb_t      ink_std, paper_std;   // Output stage, standard mode
	gggrrrbb_t  ink_px, paper_px;     // Output stage, ULAplus mode

	assign cell_pix   = beam.hc[2:0];
	assign col        = beam.hc[7:3];
	assign fetch_area = (beam.hc <= H_PIX_END) && (beam.vc <= V_PIX_END);

	////////////////////////////////////////////////////////////
	// Strobes
	////////////////////////////////////////////////////////////

	assign data_latch   = fetch_area && (cell_pix == 3'd0) && (phase == SEQ1);
	assign attr_latch   = fetch_area && (cell_pix == 3'd1) && (phase == SEQ1);
	assign paper_latch  = fetch_area && (cell_pix == 3'd2) && (phase == SEQ3);
	assign ink_latch    = fetch_area && (cell_pix == 3'd3) && (phase == SEQ3);
	assign border_latch = (cell_pix == 3'd4) && (phase == SEQ3);  // Every cell
	assign out_latch    = (cell_pix == 3'd7) && (phase == SEQ3);  // End of cell
	assign sload        = out_latch && fetch_area;

	// Bitmap uses the third, char row, pixel row interleave
	always_comb begin
		va = '0;
		if (fetch_area && (cell_pix == 3'd0))
			va = {1'b0, beam.vc[7:6], beam.vc[2:0], beam.vc[5:3], col};
		else if (fetch_area && (cell_pix == 3'd1))
			va = {4'b0110, beam.vc[7:3], col};  // Attributes at 1800
	end

	// Paper and ink in the attribute's group, border is entry 8 + border
	always_comb begin
		if (fetch_area && (cell_pix == 3'd2))
			pal_addr = {attr[7:6], 1'b1, attr[5:3]};
		else if (fetch_area && (cell_pix == 3'd3))
			pal_addr = {attr[7:6], 1'b0, attr[2:0]};
		else
			pal_addr = {3'b001, border};
	end

	// Fetch latches
	always_ff @(posedge clk28) begin
		if (data_latch)   bitmap      <= vramdata;
		if (attr_latch)   attr        <= vramdata;
		if (paper_latch)  paper_plus  <= pal_data;   // Index held since SEQ0
		if (ink_latch)    ink_plus    <= pal_data;
		if (border_latch) border_plus <= pal_data;
	end

	////////////////////////////////////////////////////////////
	// Output latch and shifter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk28) begin
		if (!rst_n) begin
			shifter   <= '0;
			ink_std   <= '0;
			paper_std <= '0;
			ink_px    <= '0;
			paper_px  <= '0;
		end else begin
			if (sload)
				shifter <= bitmap;
			else if (phase == SEQ3)
				shifter <= {shifter[6:0], 1'b0};  // MSB first
			if (out_latch) begin
				if (fetch_area) begin
					ink_std   <= {attr[6], attr[2:0]};
					paper_std <= {attr[6], attr[5:3]};
					ink_px    <= ink_plus;
					paper_px  <= paper_plus;
				end else begin
					// Border cell, same colour for both
					ink_std   <= {1'b0, border};
					paper_std <= {1'b0, border};
					ink_px    <= border_plus;
					paper_px  <= border_plus;
				end
			end
		end
	end

	function automatic rgb_t std_to_rgb(input irgb_t c);
		logic [2:0] lvl;
		rgb_t       res;
		lvl   = c[3] ? 3'b111 : 3'b101;  // Full or half intensity
		res.g = c[2] ? lvl : 3'b000;
		res.r = c[1] ? lvl : 3'b000;
		res.b = c[0] ? lvl : 3'b000;
		return res;
	endfunction

	// Blue gets its top bit repeated
	function automatic rgb_t plus_to_rgb(input gggrrrbb_t c);
		rgb_t res;
		res.g = c[7:5];
		res.r = c[4:2];
		res.b = {c[1:0], c[1]};
		return res;
	endfunction

	assign rgb = ulaplus_en ? plus_to_rgb(shifter[7] ? ink_px : paper_px) :
		std_to_rgb(shifter[7] ? ink_std : paper_std);

endmodule

`default_nettype wire

/* hw/ula.sv */
`timescale 1ns/1ps
`default_nettype none

module ula import ula_pkg::*; #(
	parameter int H_TOTAL = 448,   // 456 with 311 lines for 128K
	parameter int V_TOTAL = 312
) (
	input  wire        clk28,
	input  wire        rst_n,
	input  wire [15:0] a,
	input  wire        iorq_n,
	input  wire        rd_n,
	input  wire        wr_n,
	input  wire [7:0]  din,
	output logic [7:0] dout,
	output vaddr_t     va,
	input  wire [7:0]  vramdata,
	input  wire        ear,
	input  wire [4:0]  kbd,
	output logic       mic,
	output logic       spk,
	output logic       int_n,
	output logic [2:0] r,
	output logic [2:0] g,
	output logic [2:0] b,
	output logic       csync
);

	seq_phase_t phase;
	logic       pix_en;
	beam_t      beam;
	rgb_t       rgb_fetch, rgb_vid;
	cpu_bus_t   bus;
	pal_wr_t    pal_wr;
	pal_addr_t  pal_cpu_addr, pal_vid_addr;
	gggrrrbb_t  pal_cpu_data, pal_vid_data;
	logic [2:0] border;
	logic       ulaplus_en;

	////////////////////////////////////////////////////////////
	// Phase sequencer and frame interrupt
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk28) begin
		if (!rst_n)
			phase <= SEQ0;
		else
			phase <= seq_phase_t'(phase + 2'd1);  // Free running, wraps
	end

	assign pix_en = (phase == SEQ3);  // 7 MHz enable

	// Low for INT_LEN pixel clocks from the start of INT_LINE
	always_ff @(posedge clk28) begin
		if (!rst_n)
			int_n <= 1'b1;
		else if (pix_en && (beam.vc == INT_LINE)) begin
			if (beam.hc == '0)
				int_n <= 1'b0;
			else if (beam.hc == INT_LEN)
				int_n <= 1'b1;
		end
	end

	assign bus = '{a: a, iorq_n: iorq_n, rd_n: rd_n, wr_n: wr_n, din: din};

	pal_sync_generator #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) i_sync (
		.clk28(clk28), .rst_n(rst_n), .pix_en(pix_en), .rgb_in(rgb_fetch),
		.beam(beam), .rgb_out(rgb_vid), .csync(csync));

	ulaplus_palette_ram i_palette (
		.clk28(clk28), .wr(pal_wr), .cpu_addr(pal_cpu_addr), .cpu_data(pal_cpu_data),
		.vid_addr(pal_vid_addr), .vid_data(pal_vid_data));

	ula_io_ports i_io (
		.clk28(clk28), .rst_n(rst_n), .bus(bus), .dout(dout), .ear(ear), .kbd(kbd),
		.pal_wr(pal_wr), .pal_cpu_addr(pal_cpu_addr), .pal_cpu_data(pal_cpu_data),
		.border(border), .ulaplus_en(ulaplus_en), .mic(mic), .spk(spk));

	ula_video_fetch i_fetch (
		.clk28(clk28), .rst_n(rst_n), .phase(phase), .beam(beam), .border(border),
		.ulaplus_en(ulaplus_en), .va(va), .vramdata(vramdata),
		.pal_addr(pal_vid_addr), .pal_data(pal_vid_data), .rgb(rgb_fetch));

	assign r = rgb_vid.r;
	assign g = rgb_vid.g;
	assign b = rgb_vid.b;

endmodule

`default_nettype wire

/* verif/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int HALF_PERIOD  = 20,   // 40 ns clk28
	parameter int RESET_CYCLES = 10
) (
	output logic clk28,
	output logic rst_n
);

	initial begin
		clk28 = 1'b0;
		forever #(HALF_PERIOD) clk28 = ~clk28;
	end

	// Release lands just after an edge, like every other input
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk28);
		#2 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* verif/tb_ula.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_ula import ula_pkg::*; ();

	localparam int H_TOTAL        = 448;
	localparam int V_TOTAL        = 312;
	localparam int FRAME_CYCLES   = H_TOTAL * V_TOTAL * 4;      // clk28 per frame
	localparam int TIMEOUT_CYCLES = FRAME_CYCLES * 33 / 10;     // 3 frames + 10 %
	localparam int LOW_CYCLES     = int'(INT_LEN) * 4;
	localparam int HALF_PIX       = 256 * 192 / 2 * 4;          // Ink or paper share
	localparam int HSYNC_PIX      = int'(H_SYNC_END) - int'(H_SYNC_START) + 1;
	localparam int VSYNC_LINES    = int'(V_SYNC_END) - int'(V_SYNC_START) + 1;
	// Line pulse low, inverted on the field sync lines
	localparam int SYNC_LOW_CYCLES = 4 * ((V_TOTAL - VSYNC_LINES) * HSYNC_PIX +
		VSYNC_LINES * (H_TOTAL - HSYNC_PIX));

	logic       clk28, rst_n_gen, soft_rst_n, rst_n;
	logic [15:0] a;
	logic       iorq_n, rd_n, wr_n;
	logic [7:0] din, dout, vramdata;
	vaddr_t     va;
	logic       ear, mic, spk, int_n, csync;
	logic [4:0] kbd;
	logic [2:0] r, g, b;

	logic [7:0] pattern_byte, attr_byte;  // VRAM model contents
	logic [2:0] border_col;
	rgb_t       exp_ink, exp_paper, exp_border, px;
	logic       int_prev;
	int         frame_cycles, low_cycles, ink_hits, paper_hits, stray_hits, falls;
	int         sync_low;
	int         last_frame, last_low, last_ink, last_paper, last_stray, last_sync;
	int         errors, checks, cycle;

	tb_clock i_clock (.clk28(clk28), .rst_n(rst_n_gen));

	assign rst_n = rst_n_gen & soft_rst_n;  // Second reset comes from the test

	ula #(.H_TOTAL(H_TOTAL), .V_TOTAL(V_TOTAL)) i_dut (
		.clk28(clk28), .rst_n(rst_n), .a(a), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n),
		.din(din), .dout(dout), .va(va), .vramdata(vramdata), .ear(ear), .kbd(kbd),
		.mic(mic), .spk(spk), .int_n(int_n), .r(r), .g(g), .b(b), .csync(csync));

	// Bitmap below 1800, attributes above
	assign vramdata = (va < 14'h1800) ? pattern_byte : attr_byte;

	////////////////////////////////////////////////////////////
	// Reference colours
	////////////////////////////////////////////////////////////

	// Half level 101 with bright filling the middle bit
	function automatic rgb_t std_colour(input irgb_t c);
		rgb_t res;
		res.g = {c[2], c[2] & c[3], c[2]};
		res.r = {c[1], c[1] & c[3], c[1]};
		res.b = {c[0], c[0] & c[3], c[0]};
		return res;
	endfunction

	function automatic rgb_t plus_colour(input gggrrrbb_t c);
		rgb_t res;
		res.g = c[7:5];
		res.r = c[4:2];
		res.b = {c[1:0], c[1]};   // Low blue bit copies the high one
		return res;
	endfunction

	function automatic gggrrrbb_t rand_colour();
		return 8'($urandom_range(255, 1));  // Never black, so never mistaken for blanking
	endfunction

	////////////////////////////////////////////////////////////
	// Compare tasks and report
	////////////////////////////////////////////////////////////

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %02h, actual %02h", name, exp, act);
		end
	endtask

	task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("Fail %s: expected %03o, actual %03o", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("Fail %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic finish_run(input logic timed_out);
		$display("Checks: %0d, errors: %0d%s", checks, errors, timed_out ? ", timed out" : "");
		if (errors == 0 && !timed_out) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	endtask

	////////////////////////////////////////////////////////////
	// Bus cycles
	////////////////////////////////////////////////////////////

	task automatic wait_drive_point();
		@(posedge clk28);
		#2;
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		wait_drive_point();
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		wr_n   = 1'b0;
		repeat (3) @(posedge clk28);  // Level held for 4 edges
		wait_drive_point();
		iorq_n = 1'b1;
		wr_n   = 1'b1;
	endtask

	task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
		wait_drive_point();
		a      = addr;
		iorq_n = 1'b0;
		rd_n   = 1'b0;
		repeat (3) @(posedge clk28);
		@(negedge clk28);
		data = dout;                  // Sampled mid cycle once settled
		wait_drive_point();
		iorq_n = 1'b1;
		rd_n   = 1'b1;
	endtask

	task automatic apply_reset(input int n);
		wait_drive_point();
		soft_rst_n = 1'b0;
		repeat (n - 1) @(posedge clk28);
		wait_drive_point();
		soft_rst_n = 1'b1;
	endtask

	////////////////////////////////////////////////////////////
	// Frame monitor with one sample per clk28
	////////////////////////////////////////////////////////////

	always @(negedge clk28) begin
		if (rst_n) begin
			px = rgb_t'({r, g, b});
			if (int_prev && !int_n) begin  // Falling edge closes the frame window
				last_frame   = frame_cycles;
				last_low     = low_cycles;
				last_ink     = ink_hits;
				last_paper   = paper_hits;
				last_stray   = stray_hits;
				last_sync    = sync_low;
				frame_cycles = 0;
				low_cycles   = 0;
				ink_hits     = 0;
				paper_hits   = 0;
				stray_hits   = 0;
				sync_low     = 0;
				falls++;
			end
			frame_cycles++;
			if (!int_n)
				low_cycles++;
			if (!csync)
				sync_low++;
			if (px == exp_ink)
				ink_hits++;
			else if (px == exp_paper)
				paper_hits++;
			else if (px != '0 && px != exp_border)
				stray_hits++;  // Neither blank nor border
			int_prev = int_n;
		end
	end

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	task automatic port_fe_reads();
		logic [15:0] addr;
		logic [7:0]  got;
		for (int i = 0; i < 20; i++) begin
			addr = 16'($urandom) & 16'hFFFE;
			ear  = 1'($urandom);
			kbd  = 5'($urandom);
			io_read(addr, got);
			check_byte("port FE read", {1'b1, ear, 1'b1, kbd}, got);
		end
		for (int i = 0; i < 20; i++) begin
			addr = 16'($urandom) | 16'h0001;
			while (addr == 16'hFF3B)
				addr = 16'($urandom) | 16'h0001;
			io_read(addr, got);
			check_byte("unused port read", 8'hFF, got);
		end
	endtask

	task automatic palette_round_trip();
		pal_addr_t idx;
		gggrrrbb_t val;
		logic [7:0] got;
		for (int i = 0; i < 16; i++) begin
			idx = 6'($urandom);
			val = 8'($urandom);
			io_write(16'hBF3B, {2'b00, idx});
			io_write(16'hFF3B, val);
			io_read(16'hFF3B, got);
			check_byte($sformatf("palette entry %0d", idx), val, got);
		end
		io_write(16'hBF3B, 8'h40);   // Mode register
		io_write(16'hFF3B, 8'h03);
		io_read(16'hFF3B, got);
		check_byte("mode register", 8'h03, got);
		apply_reset(10);
		io_write(16'hBF3B, 8'h40);   // Select clears on reset too
		io_read(16'hFF3B, got);
		check_byte("mode after reset", 8'h00, got);
	endtask

	// Also covers the interrupt width and period
	task automatic standard_frame();
		logic [2:0] ink, paper;
		logic [1:0] sound;
		int         base;
		base       = falls;
		border_col = 3'($urandom_range(7, 1));
		ink        = 3'($urandom_range(7, 1));
		paper      = 3'($urandom_range(7, 1));
		while (paper == ink)
			paper = 3'($urandom_range(7, 1));
		sound        = 2'($urandom);
		pattern_byte = 8'hAA;
		attr_byte    = {1'b0, 1'b1, paper, ink};  // Bright set
		exp_ink      = std_colour({1'b1, ink});
		exp_paper    = std_colour({1'b1, paper});
		exp_border   = std_colour({1'b0, border_col});
		io_write(16'h00FE, {3'b000, sound, border_col});  // spk, mic, then border
		check_byte("spk mic after FE write", {6'b000000, sound}, {6'b000000, spk, mic});
		wait (falls == base + 1);
		wait (falls == base + 2);
		check_count("int_n low cycles", LOW_CYCLES, last_low);
		check_count("interrupt period", FRAME_CYCLES, last_frame);
		check_count("csync low cycles", SYNC_LOW_CYCLES, last_sync);
		check_count("standard ink samples", HALF_PIX, last_ink);
		check_count("standard paper samples", HALF_PIX, last_paper);
		check_count("standard stray samples", 0, last_stray);
	endtask

	// Starts right at a fall so the writes land inside the blanked lines
	task automatic ulaplus_frame();
		logic [1:0] grp;
		logic [2:0] ink, paper;
		gggrrrbb_t  ink_c, paper_c, border_c;
		int         base;
		base  = falls;
		grp   = 2'($urandom);
		ink   = 3'($urandom);
		paper = 3'($urandom);
		while (grp == 2'b00 && paper == border_col)
			paper = 3'($urandom);  // Keep clear of the border entry
		ink_c   = rand_colour();
		paper_c = rand_colour();
		while (paper_c == ink_c)
			paper_c = rand_colour();
		border_c = rand_colour();
		while (border_c == ink_c || border_c == paper_c)
			border_c = rand_colour();
		attr_byte  = {grp, paper, ink};
		exp_ink    = plus_colour(ink_c);
		exp_paper  = plus_colour(paper_c);
		exp_border = plus_colour(border_c);
		io_write(16'hBF3B, {2'b00, grp, 1'b0, ink});
		io_write(16'hFF3B, ink_c);
		io_write(16'hBF3B, {2'b00, grp, 1'b1, paper});
		io_write(16'hFF3B, paper_c);
		io_write(16'hBF3B, {2'b00, 3'b001, border_col});  // Entry 8 + border
		io_write(16'hFF3B, border_c);
		io_write(16'hBF3B, 8'h40);
		io_write(16'hFF3B, 8'h01);                         // ULAplus on
		wait (falls == base + 1);
		check_count("ULAplus interrupt period", FRAME_CYCLES, last_frame);
		check_count("ULAplus int_n low cycles", LOW_CYCLES, last_low);
		check_count("ULAplus ink samples", HALF_PIX, last_ink);
		check_count("ULAplus paper samples", HALF_PIX, last_paper);
		check_count("ULAplus stray samples", 0, last_stray);
	endtask

	initial begin
		void'($urandom(73));
		a            = '0;
		iorq_n       = 1'b1;
		rd_n         = 1'b1;
		wr_n         = 1'b1;
		din          = '0;
		ear          = 1'b0;
		kbd          = '1;
		soft_rst_n   = 1'b1;
		pattern_byte = 8'hAA;
		attr_byte    = '0;
		border_col   = '0;
		exp_ink      = '1;
		exp_paper    = '1;
		exp_border   = '0;
		int_prev     = 1'b1;
		falls        = 0;
		errors       = 0;
		checks       = 0;
		wait (rst_n_gen == 1'b1);
		@(negedge clk28);
		check_rgb("rgb after reset", '0, rgb_t'({r, g, b}));
		check_byte("int_n mic spk after reset", 8'h04, {5'b00000, int_n, mic, spk});
		port_fe_reads();
		palette_round_trip();
		standard_frame();
		ulaplus_frame();
		finish_run(1'b0);
	end

	// Watchdog
	initial begin
		cycle = 0;
		while (cycle < TIMEOUT_CYCLES) begin
			@(posedge clk28);
			cycle++;
		end
		$display("Timed out after %0d clk28 cycles, the tests never finished", cycle);
		finish_run(1'b1);
	end

endmodule

`default_nettype wire

/* tb.f */
hw/ula_pkg.sv
hw/pal_sync_generator.sv
hw/ulaplus_palette_ram.sv
hw/ula_io_ports.sv
hw/ula_video_fetch.sv
hw/ula.sv
verif/tb_clock.sv
verif/tb_ula.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the ULA testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir
BIN=tb_ula_sim

verilator --binary --timing --top-module tb_ula -f tb.f --Mdir "$OBJ" -o "$BIN"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./$OBJ/$BIN" > "$LOG" 2>&1
RUN_STATUS=$?
cat "$LOG"
if [ $RUN_STATUS -ne 0 ]; then
	echo "Simulation exited with status $RUN_STATUS"
	exit 1
fi

if grep -qx '\*\* PASS \*\*' "$LOG"; then
	echo "Result: simulation passed"
	exit 0
else
	echo "Result: simulation failed, see $LOG"
	exit 1
fi
